//--- mem_pkg.sv
// Shared types and constants for the two-way data cache and its banked memory
package mem_pkg;

   typedef logic [15:0] word_t;   // Data word and full byte address
   typedef logic [4:0]  tag_t;    // addr[15:11]
   typedef logic [7:0]  index_t;  // addr[10:3]
   typedef logic [2:0]  offset_t; // addr[2:0], bit 0 must be zero
   typedef logic [1:0]  bank_t;   // Same as word-in-line bits

   localparam int LINE_WORDS = 4;

   // Controller to both ways
   typedef struct packed {
      tag_t        tag;
      index_t      index;
      logic [1:0]  word;
      word_t       wdata;
      logic        comp;      // Compare mode, else direct access
      logic        write;
      logic        valid_in;
      logic        dirty_in;
   } cache_req_t;

   // Each way back to controller and way select
   typedef struct packed {
      logic  hit;
      logic  valid;
      logic  dirty;
      tag_t  tag;
      word_t rdata;
   } way_stat_t;

   typedef struct packed {
      word_t addr;
      word_t wdata;
      logic  wr;
      logic  rd;
   } mem_req_t;

   typedef enum logic [2:0] {
      IDLE,
      WRITEBACK,
      REFILL,
      FILL_WAIT,
      FINISH
   } ctrl_state_t;

endpackage

//--- cache_way.sv
// One cache way with tag, valid, dirty and data storage plus tag compare
`timescale 1ns/1ps

module cache_way (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  enable,
   input  mem_pkg::cache_req_t   req,
   output mem_pkg::way_stat_t    stat
);
   import mem_pkg::*;

   localparam int LINES = 1 << $bits(index_t);

   tag_t             tag_q  [LINES];
   word_t            data_q [LINES][LINE_WORDS];
   logic [LINES-1:0] valid_q;
   logic [LINES-1:0] dirty_q;

   logic tag_eq;
   logic wr_en;

   assign tag_eq = (tag_q[req.index] == req.tag);

   // Lookup is purely combinational
   always_comb begin
      stat.valid = valid_q[req.index];
      stat.dirty = dirty_q[req.index];
      stat.tag   = tag_q[req.index];
      stat.rdata = data_q[req.index][req.word];
      stat.hit   = enable & req.comp & tag_eq & valid_q[req.index];
   end

   // Compare-mode writes only land on a hit
   assign wr_en = enable & req.write & (~req.comp | stat.hit);

   always_ff @(posedge clk) begin
      if (wr_en) begin
         data_q[req.index][req.word] <= req.wdata;
         if (!req.comp) begin
            tag_q[req.index] <= req.tag;  // Refill installs the new tag
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else if (wr_en) begin
         if (req.comp) begin
            dirty_q[req.index] <= 1'b1;  // Write hit
         end else begin
            valid_q[req.index] <= req.valid_in;
            dirty_q[req.index] <= req.dirty_in;
         end
      end
   end

endmodule

//--- bank_mem.sv
// Four-bank interleaved main memory with per-bank busy time and fixed read latency
`timescale 1ns/1ps

module bank_mem #(
   parameter int MEM_LATENCY = 2,
   parameter int BANK_BUSY   = 4
) (
   input  logic               clk,
   input  logic               rst_n,
   input  mem_pkg::mem_req_t  req,
   output mem_pkg::word_t     rdata,
   output logic               rvalid,
   output logic [3:0]         bank_busy
);
   import mem_pkg::*;

   localparam int BANKS = 1 << $bits(bank_t);
   localparam int ROWS  = 8192;
   localparam int CW    = $clog2(BANK_BUSY + 1);

   // Starts out all zero, so untouched words read back as zero
   word_t mem_q [BANKS][ROWS] = '{default: '0};

   bank_t            bank;
   logic [12:0]      row;
   logic [CW-1:0]    busy_cnt [BANKS];
   word_t            dl_data  [MEM_LATENCY];
   logic [MEM_LATENCY-1:0] dl_valid;

   assign bank = req.addr[2:1];
   assign row  = req.addr[15:3];

   // Storage and read data pipeline
   always_ff @(posedge clk) begin
      if (req.wr) begin
         mem_q[bank][row] <= req.wdata;
      end
      dl_data[0] <= mem_q[bank][row];
      for (int i = 1; i < MEM_LATENCY; i++) begin
         dl_data[i] <= dl_data[i-1];
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         dl_valid <= '0;
      end else begin
         dl_valid[0] <= req.rd;
         for (int i = 1; i < MEM_LATENCY; i++) begin
            dl_valid[i] <= dl_valid[i-1];
         end
      end
   end

   assign rdata  = dl_data[MEM_LATENCY-1];
   assign rvalid = dl_valid[MEM_LATENCY-1];

   // Each access reloads that bank's busy counter
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < BANKS; i++) begin
            busy_cnt[i] <= '0;
         end
      end else begin
         for (int i = 0; i < BANKS; i++) begin
            if ((req.rd | req.wr) && bank == bank_t'(i)) begin
               busy_cnt[i] <= CW'(BANK_BUSY);
            end else if (busy_cnt[i] != '0) begin
               busy_cnt[i] <= busy_cnt[i] - 1'b1;
            end
         end
      end
   end

   always_comb begin
      for (int i = 0; i < BANKS; i++) begin
         bank_busy[i] = (busy_cnt[i] != '0);
      end
   end

endmodule

//--- way_select.sv
// Hit detection across both ways and victim choice with a toggling fallback
`timescale 1ns/1ps

module way_select (
   input  logic                clk,
   input  logic                rst_n,
   input  mem_pkg::way_stat_t  stat0,
   input  mem_pkg::way_stat_t  stat1,
   input  logic                accept,
   output logic                any_hit,
   output logic                hit_way,
   output logic                victim_way
);
   import mem_pkg::*;

   logic toggle_q;

   assign any_hit = stat0.hit | stat1.hit;
   assign hit_way = ~stat0.hit & stat1.hit;  // Both can't hit the same tag

   // Prefer an empty way before evicting anything
   always_comb begin
      if (!stat0.valid) begin
         victim_way = 1'b0;
      end else if (!stat1.valid) begin
         victim_way = 1'b1;
      end else begin
         victim_way = toggle_q;
      end
   end

   // Pseudo-random pick, flips on every accepted request
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         toggle_q <= 1'b0;
      end else if (accept) begin
         toggle_q <= ~toggle_q;
      end
   end

endmodule

//--- cache_ctrl.sv
// Cache controller FSM sequencing hits, write-backs and refills into registered outputs
`timescale 1ns/1ps

module cache_ctrl (
   input  logic                 clk,
   input  logic                 rst_n,
   input  mem_pkg::word_t       addr,
   input  mem_pkg::word_t       data_in,
   input  logic                 rd,
   input  logic                 wr,
   input  mem_pkg::way_stat_t   stat0,
   input  mem_pkg::way_stat_t   stat1,
   input  logic                 any_hit,
   input  logic                 hit_way,
   input  logic                 victim_way,
   input  mem_pkg::word_t       mem_rdata,
   input  logic                 mem_rvalid,
   input  logic [3:0]           bank_busy,
   output mem_pkg::cache_req_t  creq,
   output logic                 en0,
   output logic                 en1,
   output logic                 accept,
   output mem_pkg::mem_req_t    mreq,
   output mem_pkg::word_t       data_out,
   output logic                 done,
   output logic                 stall,
   output logic                 cache_hit,
   output logic                 err
);
   import mem_pkg::*;

   localparam logic [1:0] LAST_WORD = 2'(LINE_WORDS - 1);

   ctrl_state_t state_q;

   // Latched request and victim
   word_t      req_addr_q;
   word_t      req_data_q;
   logic       req_wr_q;
   logic       vic_q;
   tag_t       vic_tag_q;

   logic [1:0] iss_cnt_q;
   logic [1:0] ret_cnt_q;
   word_t      data_out_q;
   logic       done_q;
   logic       hit_q;
   logic       stall_q;
   logic       err_q;

   offset_t    in_off;
   logic       req_bad;
   logic       req_ok;
   word_t      cur_addr;
   tag_t       cur_tag;
   index_t     cur_index;
   bank_t      iss_bank;
   logic       can_issue;
   logic       vic_dirty;
   tag_t       vic_tag;
   word_t      vic_rdata;
   word_t      hit_rdata;

   // Decode of the incoming request
   assign in_off  = addr[2:0];
   assign req_bad = (state_q == IDLE) & ((rd & wr) | ((rd | wr) & in_off[0]));
   assign req_ok  = (state_q == IDLE) & (rd ^ wr) & ~in_off[0];
   assign accept  = req_ok;

   assign cur_addr  = (state_q == IDLE) ? addr : req_addr_q;
   assign cur_tag   = cur_addr[15:11];
   assign cur_index = cur_addr[10:3];

   assign iss_bank  = iss_cnt_q;  // Word n of a line sits in bank n
   assign can_issue = ~bank_busy[iss_bank];

   assign vic_dirty = victim_way ? (stat1.valid & stat1.dirty) : (stat0.valid & stat0.dirty);
   assign vic_tag   = victim_way ? stat1.tag : stat0.tag;
   assign vic_rdata = vic_q ? stat1.rdata : stat0.rdata;
   assign hit_rdata = hit_way ? stat1.rdata : stat0.rdata;

   always_comb begin
      creq       = '0;
      creq.tag   = cur_tag;
      creq.index = cur_index;
      creq.word  = cur_addr[2:1];
      en0        = 1'b0;
      en1        = 1'b0;
      mreq       = '0;
      case (state_q)
         IDLE: begin
            creq.comp  = 1'b1;
            creq.write = req_ok & wr;
            creq.wdata = data_in;
            en0        = req_ok;
            en1        = req_ok;
         end
         WRITEBACK: begin
            creq.word  = iss_cnt_q;  // Read victim word straight out
            en0        = ~vic_q;
            en1        = vic_q;
            mreq.addr  = {vic_tag_q, cur_index, iss_cnt_q, 1'b0};
            mreq.wdata = vic_rdata;
            mreq.wr    = can_issue;
         end
         REFILL, FILL_WAIT: begin
            mreq.addr     = {cur_tag, cur_index, iss_cnt_q, 1'b0};
            mreq.rd       = (state_q == REFILL) & can_issue;
            creq.word     = ret_cnt_q;
            creq.wdata    = mem_rdata;
            creq.write    = mem_rvalid;
            creq.valid_in = 1'b1;
            en0           = ~vic_q;
            en1           = vic_q;
         end
         FINISH: begin
            // Replay original access, now a hit
            creq.comp  = 1'b1;
            creq.write = req_wr_q;
            creq.wdata = req_data_q;
            en0        = 1'b1;
            en1        = 1'b1;
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q   <= IDLE;
         done_q    <= 1'b0;
         hit_q     <= 1'b0;
         stall_q   <= 1'b0;
         err_q     <= 1'b0;
         iss_cnt_q <= '0;
         ret_cnt_q <= '0;
      end else begin
         done_q <= 1'b0;
         hit_q  <= 1'b0;
         err_q  <= req_bad;
         case (state_q)
            IDLE: begin
               if (req_ok && any_hit) begin
                  done_q <= 1'b1;
                  hit_q  <= 1'b1;
               end else if (req_ok) begin
                  stall_q <= 1'b1;
                  state_q <= vic_dirty ? WRITEBACK : REFILL;
               end
            end
            WRITEBACK: begin
               if (can_issue) begin
                  iss_cnt_q <= iss_cnt_q + 1'b1;
                  if (iss_cnt_q == LAST_WORD) begin
                     state_q <= REFILL;
                  end
               end
            end
            REFILL: begin
               if (can_issue) begin
                  iss_cnt_q <= iss_cnt_q + 1'b1;
                  if (iss_cnt_q == LAST_WORD) begin
                     state_q <= FILL_WAIT;
                  end
               end
               if (mem_rvalid) begin
                  ret_cnt_q <= ret_cnt_q + 1'b1;
               end
            end
            FILL_WAIT: begin
               if (mem_rvalid) begin
                  ret_cnt_q <= ret_cnt_q + 1'b1;
                  if (ret_cnt_q == LAST_WORD) begin
                     state_q <= FINISH;
                  end
               end
            end
            FINISH: begin
               done_q  <= 1'b1;
               stall_q <= 1'b0;  // Falls together with done
               state_q <= IDLE;
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (req_ok) begin
         req_addr_q <= addr;
         req_data_q <= data_in;
         req_wr_q   <= wr;
         vic_q      <= victim_way;
         vic_tag_q  <= vic_tag;
      end
      if (req_ok && any_hit && rd) begin
         data_out_q <= hit_rdata;
      end else if (state_q == FINISH && !req_wr_q) begin
         data_out_q <= hit_rdata;
      end
   end

   assign data_out  = data_out_q;
   assign done      = done_q;
   assign stall     = stall_q;
   assign cache_hit = hit_q;
   assign err       = err_q;

endmodule

//--- mem_system.sv
// Top level of the two-way cache, controller and banked main memory
`timescale 1ns/1ps

module mem_system #(
   parameter int MEM_LATENCY = 2,
   parameter int BANK_BUSY   = 4
) (
   input  logic            clk,
   input  logic            rst_n,
   input  mem_pkg::word_t  addr,
   input  mem_pkg::word_t  data_in,
   input  logic            rd,
   input  logic            wr,
   output mem_pkg::word_t  data_out,
   output logic            done,
   output logic            stall,
   output logic            cache_hit,
   output logic            err
);
   import mem_pkg::*;

   cache_req_t  creq;
   way_stat_t   stat0;
   way_stat_t   stat1;
   mem_req_t    mreq;
   word_t       mem_rdata;
   logic        mem_rvalid;
   logic [3:0]  bank_busy;
   logic        en0;
   logic        en1;
   logic        any_hit;
   logic        hit_way;
   logic        victim_way;
   logic        accept;

   cache_way way0 (
      .clk    (clk),
      .rst_n  (rst_n),
      .enable (en0),
      .req    (creq),
      .stat   (stat0)
   );

   cache_way way1 (
      .clk    (clk),
      .rst_n  (rst_n),
      .enable (en1),
      .req    (creq),
      .stat   (stat1)
   );

   way_select sel (
      .clk        (clk),
      .rst_n      (rst_n),
      .stat0      (stat0),
      .stat1      (stat1),
      .accept     (accept),
      .any_hit    (any_hit),
      .hit_way    (hit_way),
      .victim_way (victim_way)
   );

   cache_ctrl ctrl (
      .clk        (clk),
      .rst_n      (rst_n),
      .addr       (addr),
      .data_in    (data_in),
      .rd         (rd),
      .wr         (wr),
      .stat0      (stat0),
      .stat1      (stat1),
      .any_hit    (any_hit),
      .hit_way    (hit_way),
      .victim_way (victim_way),
      .mem_rdata  (mem_rdata),
      .mem_rvalid (mem_rvalid),
      .bank_busy  (bank_busy),
      .creq       (creq),
      .en0        (en0),
      .en1        (en1),
      .accept     (accept),
      .mreq       (mreq),
      .data_out   (data_out),
      .done       (done),
      .stall      (stall),
      .cache_hit  (cache_hit),
      .err        (err)
   );

   bank_mem #(
      .MEM_LATENCY (MEM_LATENCY),
      .BANK_BUSY   (BANK_BUSY)
   ) mem (
      .clk       (clk),
      .rst_n     (rst_n),
      .req       (mreq),
      .rdata     (mem_rdata),
      .rvalid    (mem_rvalid),
      .bank_busy (bank_busy)
   );

endmodule

//--- tb_mem_system.sv
// Testbench for the two-way cache system with a flat reference memory and concurrent checks
`timescale 1ns/1ps

module tb_mem_system;
   import mem_pkg::*;

   localparam int TESTBENCH_DEPTH = 32768;  // Words in the 64 KB address space
   localparam int N_RAND     = 300;
   localparam int N_DIRECTED = 4 * 9;
   localparam int N_ERR      = 6;
   localparam int MAX_REQS   = N_DIRECTED + N_ERR + 2 * N_RAND;
   localparam int MAX_CYCLES = 40 * MAX_REQS + 10;

   logic  clk = 1'b0;
   logic  rst_n;
   word_t addr;
   word_t data_in;
   logic  rd;
   logic  wr;
   word_t data_out;
   logic  done;
   logic  stall;
   logic  cache_hit;
   logic  err;

   bit [15:0]   ref_mem [TESTBENCH_DEPTH];
   bit          touched [TESTBENCH_DEPTH / 4];  // Lines accessed since reset
   bit [15:0]   exp_data;
   bit          pend_rd;
   bit          hit_req;
   bit          miss_req;
   bit          bad_req;
   int          outstanding;
   int          cyc;
   logic [31:0] rng = 32'd10;

   mem_system dut0 (
      .clk       (clk),
      .rst_n     (rst_n),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   always #2 clk = ~clk;

   always @(posedge clk) cyc <= cyc + 1;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic stop_on_mismatch(input string sig, input logic [15:0] expected,
                                   input logic [15:0] actual);
      $display("Error at %0d ns: %s expected %h, got %h", $time, sig, expected, actual);
      $display("CHECKS FAILED");
      $fatal(1, "run stopped at the first mismatch");
   endtask

   task automatic stop_with_message(input string msg);
      $display("%s at %0d ns", msg, $time);
      $display("CHECKS FAILED");
      $fatal(1, "run stopped");
   endtask

   // Drives one legal request and returns on the edge where done is seen
   task automatic issue_request(input word_t a, input word_t d, input logic is_wr,
                                input logic again);
      hit_req  = again;
      miss_req = !touched[a[15:3]];
      pend_rd  = !is_wr;
      exp_data = ref_mem[a[15:1]];
      outstanding = 1;
      touched[a[15:3]] = 1'b1;
      if (is_wr) ref_mem[a[15:1]] = d;
      addr    <= a;
      data_in <= d;
      rd      <= !is_wr;
      wr      <= is_wr;
      @(posedge clk);
      rd <= 1'b0;
      wr <= 1'b0;
      @(posedge clk);
      while (!done) @(posedge clk);
      outstanding = 0;
   endtask

   task automatic send_illegal(input word_t a, input word_t d, input logic r, input logic w);
      hit_req  = 1'b0;
      miss_req = 1'b0;
      bad_req  = 1'b1;
      addr    <= a;
      data_in <= d;
      rd      <= r;
      wr      <= w;
      @(posedge clk);
      rd <= 1'b0;
      wr <= 1'b0;
      repeat (3) @(posedge clk);  // err comes one cycle after acceptance would
      bad_req = 1'b0;
   endtask

   // Three tags on one index force dirty evictions
   task automatic run_conflicts(input index_t idx);
      word_t a [3];
      for (int t = 0; t < 3; t++) begin
         a[t] = {tag_t'(t * 7 + 3), idx, 2'(t), 1'b0};
      end
      for (int t = 0; t < 3; t++) begin
         rng = xorshift32(rng);
         issue_request(a[t], rng[15:0], 1'b1, 1'b0);
      end
      for (int t = 0; t < 3; t++) begin
         issue_request(a[t], 16'h0, 1'b0, 1'b0);
         issue_request(a[t], 16'h0, 1'b0, 1'b1);  // Same word again
      end
   endtask

   a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
      done && pend_rd |-> data_out == exp_data)
      else stop_on_mismatch("data_out", $sampled(exp_data), $sampled(data_out));
   a_hit: assert property (@(posedge clk) disable iff (!rst_n)
      (rd || wr) && hit_req |=> done && cache_hit && !stall)
      else stop_on_mismatch("done/cache_hit/stall", 3'b110, $sampled({done, cache_hit, stall}));
   a_miss_start: assert property (@(posedge clk) disable iff (!rst_n)
      (rd || wr) && miss_req |=> stall && !done)
      else stop_on_mismatch("stall/done", 2'b10, $sampled({stall, done}));
   a_miss_end: assert property (@(posedge clk) disable iff (!rst_n)
      done && miss_req |-> !cache_hit && !stall)
      else stop_on_mismatch("cache_hit/stall", 2'b00, $sampled({cache_hit, stall}));
   a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
      stall |=> (stall && !done) || (done && !stall))
      else stop_with_message("stall did not stay high until done");
   a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      done |=> !done)
      else stop_on_mismatch("done", 16'h0, $sampled(done));
   a_done_once: assert property (@(posedge clk) disable iff (!rst_n)
      done |-> outstanding == 1)
      else stop_with_message("done without an accepted request");
   a_no_stall_req: assert property (@(posedge clk) disable iff (!rst_n)
      (rd || wr) |-> !stall)
      else stop_with_message("request driven while stall was high");
   a_err_set: assert property (@(posedge clk) disable iff (!rst_n)
      (rd || wr) && bad_req |=> err && !done)
      else stop_on_mismatch("err/done", 2'b10, $sampled({err, done}));
   a_err_clear: assert property (@(posedge clk) disable iff (!rst_n)
      ((rd || wr) && !bad_req) || err |=> !err)
      else stop_on_mismatch("err", 16'h0, $sampled(err));
   a_reset: assert property (@(posedge clk)
      cyc >= 1 && cyc <= 3 |-> !done && !stall && !cache_hit && !err)
      else stop_on_mismatch("done/stall/cache_hit/err", 16'h0,
                            $sampled({done, stall, cache_hit, err}));

   initial begin
      while (cyc < MAX_CYCLES) @(posedge clk);
      stop_with_message("Timeout, requests did not finish in the cycle budget");
   end

   initial begin
      word_t a;
      word_t d;
      logic  is_wr;
      rst_n   = 1'b0;
      rd      = 1'b0;
      wr      = 1'b0;
      addr    = '0;
      data_in = '0;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      repeat (2) @(posedge clk);
      for (int i = 0; i < 4; i++) begin
         run_conflicts(index_t'(32 + i * 49));
      end
      // Illegal requests must leave this word alone
      a = {5'd9, 8'h20, 2'd1, 1'b0};
      issue_request(a, 16'h1234, 1'b1, 1'b0);
      send_illegal(a, 16'hdead, 1'b1, 1'b1);
      send_illegal(a | 16'h1, 16'hbeef, 1'b0, 1'b1);
      send_illegal(a | 16'h1, 16'h0, 1'b1, 1'b0);
      issue_request(a, 16'h0, 1'b0, 1'b0);
      issue_request(a, 16'h0, 1'b0, 1'b1);
      for (int n = 0; n < N_RAND; n++) begin
         rng   = xorshift32(rng);
         a     = {rng[4:0], rng[6:5], 6'h15, rng[8:7], 1'b0};  // Four indexes and all tags
         d     = rng[31:16];
         is_wr = rng[9];
         issue_request(a, d, is_wr, 1'b0);
         if (!is_wr && rng[10]) begin
            issue_request(a, 16'h0, 1'b0, 1'b1);
         end
      end
      repeat (3) @(posedge clk);
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

//--- all.f
mem_pkg.sv
cache_way.sv
bank_mem.sv
way_select.sv
cache_ctrl.sv
mem_system.sv
tb_mem_system.sv

//--- Bender.yml
package:
  name: mem_system

sources:
  - mem_pkg.sv
  - cache_way.sv
  - bank_mem.sv
  - way_select.sv
  - cache_ctrl.sv
  - mem_system.sv
  - target: test
    files:
      - tb_mem_system.sv
